/* design/fp_pkg.sv */
// shared opcodes, widths, constants and stream structs for the single-precision FPU, import with fp_pkg::*
`default_nettype none

package fp_pkg;

    // ====================
    // widths and constants
    // ====================
    localparam int FP_W   = 32;                          // operand width
    localparam int EXP_W  = 8;                           // exponent field
    localparam int MAN_W  = 23;                          // fraction field, hidden bit not stored
    localparam logic [EXP_W-1:0] EXP_MAX = 8'd255;       // inf / nan exponent
    localparam int FLAG_W = 5;                           // number of exception flags
    localparam int TAG_W  = 4;                           // request tag

    localparam logic [FP_W-1:0] QNAN_INF_ZERO = 32'h7FC0_0004;  // origin code 4 = inf * zero

    // compare mask bit positions
    localparam int CMP_EQ = 0;
    localparam int CMP_LT = 1;
    localparam int CMP_LE = 2;
    localparam int CMP_UN = 3;                           // unordered, some operand is nan

    // ====================
    // opcodes
    // ====================
    typedef enum logic [3:0] {
        FMOV,                                            // sign ops, single cycle
        FNEG,
        FABS,
        FNABS,
        FSIGN,
        FCMP,                                            // relation mask
        FMUL,                                            // three stage multiplier
        FSTAT,                                           // read status
        FTX,                                             // trigger flags from mask
        FCX,                                             // clear flags
        FEX,                                             // enable exceptions
        FDX                                              // disable exceptions
    } fp_op_e;

    // ====================
    // stream payloads
    // ====================
    typedef struct packed {
        logic nx;                                        // inexact
        logic dz;                                        // divide by zero, never raised by arithmetic here
        logic uf;                                        // underflow
        logic of;                                        // overflow
        logic nv;                                        // invalid
    } fp_flags_t;                                        // same order as a[4:0] of a control op

    typedef struct packed {
        fp_op_e            op;
        logic [FP_W-1:0]   a;
        logic [FP_W-1:0]   b;
        logic [TAG_W-1:0]  tag;
    } fp_req_t;                                          // 72 bits

    typedef struct packed {
        logic [FP_W-1:0]   result;
        fp_flags_t         flags;
        logic [TAG_W-1:0]  tag;                          // echoed from the request
    } fp_rsp_t;                                          // 41 bits

    typedef struct packed {
        fp_flags_t enables;                              // upper five bits
        fp_flags_t flags;                                // sticky, lower five bits
    } fp_status_t;

endpackage

`default_nettype wire

/* design/fp_dispatch.sv */
// request decoder, steers each op to the misc unit or the multiplier and flags control ops
`default_nettype none
`timescale 1ns/100ps

module fp_dispatch import fp_pkg::*; (
    input  wire logic    req_valid_i,
    input  fp_req_t      req_i,
    output logic         req_ready_o,
    output logic         misc_valid_o,
    output fp_req_t      misc_req_o,
    input  wire logic    misc_ready_i,
    output logic         mul_valid_o,
    output fp_req_t      mul_req_o,
    input  wire logic    mul_ready_i,
    output logic         ctl_valid_o,
    output fp_req_t      ctl_req_o
);

    logic is_mul;                                        // only fmul goes down the pipe
    logic is_ctl;                                        // ftx / fcx / fex / fdx

    assign is_mul = (req_i.op == FMUL);
    assign is_ctl = (req_i.op == FTX) || (req_i.op == FCX) ||
                    (req_i.op == FEX) || (req_i.op == FDX);

    // both units see the same payload, valid picks the target
    assign misc_valid_o = req_valid_i & ~is_mul;
    assign mul_valid_o  = req_valid_i &  is_mul;
    assign misc_req_o   = req_i;
    assign mul_req_o    = req_i;

    // ready comes from whichever unit is addressed, both are low in reset
    assign req_ready_o  = is_mul ? mul_ready_i : misc_ready_i;

    // status side effect fires in the same cycle misc takes the ack op
    assign ctl_valid_o  = req_valid_i & is_ctl & misc_ready_i;
    assign ctl_req_o    = req_i;

endmodule

`default_nettype wire

/* design/fp_misc_unit.sv */
// single-cycle unit for sign ops, compare, status read and control-op acks, result held until taken
`default_nettype none
`timescale 1ns/100ps

module fp_misc_unit import fp_pkg::*; (
    input  wire logic    clk,
    input  wire logic    rst,
    input  wire logic    in_valid_i,
    input  fp_req_t      in_req_i,
    output logic         in_ready_o,
    input  fp_status_t   status_i,
    output logic         out_valid_o,
    output fp_rsp_t      out_rsp_o,
    input  wire logic    out_ready_i
);

    logic [FP_W-1:0] opa, opb;
    logic            a_nan, b_nan, unord, a_zero, both_zero, eq, lt;
    logic [3:0]      cmp;                                // relation mask
    fp_rsp_t         rsp_d;

    assign opa       = in_req_i.a;
    assign opb       = in_req_i.b;
    assign a_nan     = (opa[FP_W-2 -: EXP_W] == EXP_MAX) && (opa[MAN_W-1:0] != '0);
    assign b_nan     = (opb[FP_W-2 -: EXP_W] == EXP_MAX) && (opb[MAN_W-1:0] != '0);
    assign unord     = a_nan | b_nan;
    assign a_zero    = (opa[FP_W-2:0] == '0);
    assign both_zero = a_zero && (opb[FP_W-2:0] == '0);  // +0 == -0
    assign eq        = (opa == opb) | both_zero;

    // ====================
    // compare
    // ====================
    always_comb begin
        if (opa[FP_W-1] != opb[FP_W-1])
            lt = opa[FP_W-1] & ~both_zero;              // negative below positive
        else if (opa[FP_W-1])
            lt = opa[FP_W-2:0] > opb[FP_W-2:0];         // both negative, larger magnitude is less
        else
            lt = opa[FP_W-2:0] < opb[FP_W-2:0];
        cmp = '0;
        if (unord) begin
            cmp[CMP_UN] = 1'b1;                          // nothing else is set
        end else begin
            cmp[CMP_EQ] = eq;
            cmp[CMP_LT] = lt;
            cmp[CMP_LE] = eq | lt;
        end
    end

    // result mux
    always_comb begin
        rsp_d        = '0;                               // control ops ack with zero
        rsp_d.tag    = in_req_i.tag;
        case (in_req_i.op)
            FMOV:  rsp_d.result = opa;
            FNEG:  rsp_d.result = {~opa[FP_W-1], opa[FP_W-2:0]};
            FABS:  rsp_d.result = {1'b0, opa[FP_W-2:0]};
            FNABS: rsp_d.result = {1'b1, opa[FP_W-2:0]};
            FSIGN: rsp_d.result = a_zero ? {opa[FP_W-1], {(FP_W-1){1'b0}}}
                                         : {opa[FP_W-1], 1'b0, {(EXP_W-1){1'b1}}, {MAN_W{1'b0}}};
            FCMP: begin
                rsp_d.result   = FP_W'(cmp);
                rsp_d.flags.nv = unord;                  // nan compare is invalid
            end
            FSTAT: rsp_d.result = FP_W'(status_i);       // zero extended
            default: ;
        endcase
    end

    // take a new op when empty or draining this cycle
    assign in_ready_o = ~rst & (~out_valid_o | out_ready_i);

    always_ff @(posedge clk) begin
        if (rst)
            out_valid_o <= 1'b0;
        else if (in_ready_o)
            out_valid_o <= in_valid_i;
        if (in_valid_i && in_ready_o)
            out_rsp_o <= rsp_d;                          // held otherwise
    end

endmodule

`default_nettype wire

/* design/fp_mul_pipe.sv */
// three-stage single-precision multiplier, round to nearest even, flush to zero, stalls as a whole
`default_nettype none
`timescale 1ns/100ps

module fp_mul_pipe import fp_pkg::*; (
    input  wire logic    clk,
    input  wire logic    rst,
    input  wire logic    in_valid_i,
    input  fp_req_t      in_req_i,
    output logic         in_ready_o,
    output logic         out_valid_o,
    output fp_rsp_t      out_rsp_o,
    input  wire logic    out_ready_i
);

    logic adv;                                           // whole pipe moves together
    assign adv        = ~out_valid_o | out_ready_i;
    assign in_ready_o = ~rst & adv;

    // ====================
    // stage 1, unpack and classify
    // ====================
    logic [EXP_W-1:0] ea, eb;
    logic             sgn, a_zero, b_zero, a_inf, b_inf, a_nan, b_nan;
    logic             spec_d;                            // result fully decided here
    logic [FP_W-1:0]  spec_res;
    fp_flags_t        spec_flags;

    assign ea     = in_req_i.a[MAN_W +: EXP_W];
    assign eb     = in_req_i.b[MAN_W +: EXP_W];
    assign sgn    = in_req_i.a[FP_W-1] ^ in_req_i.b[FP_W-1];
    assign a_zero = (ea == '0);                          // subnormals count as zero
    assign b_zero = (eb == '0);
    assign a_inf  = (ea == EXP_MAX) && (in_req_i.a[MAN_W-1:0] == '0);
    assign b_inf  = (eb == EXP_MAX) && (in_req_i.b[MAN_W-1:0] == '0);
    assign a_nan  = (ea == EXP_MAX) && (in_req_i.a[MAN_W-1:0] != '0);
    assign b_nan  = (eb == EXP_MAX) && (in_req_i.b[MAN_W-1:0] != '0);

    always_comb begin
        spec_d     = 1'b1;
        spec_res   = {sgn, {(FP_W-1){1'b0}}};            // signed zero by default
        spec_flags = '0;
        if (a_nan | b_nan) begin
            spec_res          = a_nan ? in_req_i.a : in_req_i.b;   // a wins
            spec_res[MAN_W-1] = 1'b1;                    // make it quiet
            spec_flags.nv     = (a_nan & ~in_req_i.a[MAN_W-1]) | (b_nan & ~in_req_i.b[MAN_W-1]);
        end else if ((a_inf & b_zero) | (a_zero & b_inf)) begin
            spec_res      = QNAN_INF_ZERO;
            spec_flags.nv = 1'b1;
        end else if (a_inf | b_inf) begin
            spec_res = {sgn, EXP_MAX, {MAN_W{1'b0}}};
        end else if (!(a_zero | b_zero)) begin
            spec_d = 1'b0;                               // ordinary finite product
        end
    end

    logic             s1_valid, s1_sign, s1_spec;
    logic [EXP_W-1:0] s1_ea, s1_eb;
    logic [MAN_W:0]   s1_ma, s1_mb;                      // with hidden one
    fp_rsp_t          s1_rsp;                            // special result, flags and tag

    // stage 2 state, product and biased exponent sum
    logic                   s2_valid, s2_sign, s2_spec;
    logic signed [EXP_W+1:0] s2_exp;
    logic [2*MAN_W+1:0]     s2_prod;                     // 48 bits
    fp_rsp_t                s2_rsp;

    // stage 3, normalize and round
    logic [MAN_W-1:0]        frac;
    logic [MAN_W:0]          frac_r;                     // carry on top
    logic                    guard, sticky, rnd_up;
    logic signed [EXP_W+1:0] exp_n, exp_r;
    fp_rsp_t                 res_d;

    always_comb begin
        if (s2_prod[2*MAN_W+1]) begin                    // product in [2,4)
            frac   = s2_prod[2*MAN_W -: MAN_W];
            guard  = s2_prod[MAN_W];
            sticky = |s2_prod[MAN_W-1:0];
            exp_n  = s2_exp + 10'sd1;
        end else begin
            frac   = s2_prod[2*MAN_W-1 -: MAN_W];
            guard  = s2_prod[MAN_W-1];
            sticky = |s2_prod[MAN_W-2:0];
            exp_n  = s2_exp;
        end
        rnd_up = guard & (sticky | frac[0]);             // ties to even
        frac_r = {1'b0, frac} + {{MAN_W{1'b0}}, rnd_up};
        exp_r  = exp_n + $signed({{(EXP_W+1){1'b0}}, frac_r[MAN_W]});
        res_d  = s2_rsp;
        if (!s2_spec) begin
            res_d.flags.nx = guard | sticky;
            if (exp_r >= $signed({2'b00, EXP_MAX})) begin
                res_d.result   = {s2_sign, EXP_MAX, {MAN_W{1'b0}}};     // overflow to inf
                res_d.flags.of = 1'b1;
                res_d.flags.nx = 1'b1;
            end else if (exp_r <= 10'sd0) begin
                res_d.result   = {s2_sign, {(FP_W-1){1'b0}}};           // flush to zero
                res_d.flags.uf = 1'b1;
                res_d.flags.nx = 1'b1;
            end else begin
                res_d.result = {s2_sign, exp_r[EXP_W-1:0], frac_r[MAN_W-1:0]};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid    <= 1'b0;
            s2_valid    <= 1'b0;
            out_valid_o <= 1'b0;
        end else if (adv) begin
            s1_valid    <= in_valid_i;
            s2_valid    <= s1_valid;
            out_valid_o <= s2_valid;
        end
        if (adv) begin
            s1_sign   <= sgn;
            s1_spec   <= spec_d;
            s1_ea     <= ea;
            s1_eb     <= eb;
            s1_ma     <= {1'b1, in_req_i.a[MAN_W-1:0]};
            s1_mb     <= {1'b1, in_req_i.b[MAN_W-1:0]};
            s1_rsp    <= '{result: spec_res, flags: spec_flags, tag: in_req_i.tag};
            s2_sign   <= s1_sign;
            s2_spec   <= s1_spec;
            s2_exp    <= $signed({2'b00, s1_ea}) + $signed({2'b00, s1_eb}) - 10'sd127; // rebias
            s2_prod   <= s1_ma * s1_mb;
            s2_rsp    <= s1_rsp;
            out_rsp_o <= res_d;
        end
    end

endmodule

`default_nettype wire

/* design/fp_result_arbiter.sv */
// merges multiplier and misc results onto the response port, multiplier first, grant held while stalled
`default_nettype none
`timescale 1ns/100ps

module fp_result_arbiter import fp_pkg::*; (
    input  wire logic    clk,
    input  wire logic    rst,
    input  wire logic    mul_valid_i,
    input  fp_rsp_t      mul_rsp_i,
    output logic         mul_ready_o,
    input  wire logic    misc_valid_i,
    input  fp_rsp_t      misc_rsp_i,
    output logic         misc_ready_o,
    output logic         rsp_valid_o,
    output fp_rsp_t      rsp_o,
    input  wire logic    rsp_ready_i,
    output logic         rsp_fire_o
);

    logic grant_mul;
    logic lock_q;                                        // response stalled last cycle
    logic lock_mul_q;                                    // who owned the port then

    // a stalled response keeps its owner so the payload cannot switch under it
    assign grant_mul    = lock_q ? lock_mul_q : mul_valid_i;

    assign rsp_valid_o  = mul_valid_i | misc_valid_i;
    assign rsp_o        = grant_mul ? mul_rsp_i : misc_rsp_i;
    assign mul_ready_o  =  grant_mul & rsp_ready_i;      // only the owner sees ready
    assign misc_ready_o = ~grant_mul & rsp_ready_i;
    assign rsp_fire_o   = rsp_valid_o & rsp_ready_i;

    always_ff @(posedge clk) begin
        if (rst)
            lock_q <= 1'b0;
        else
            lock_q <= rsp_valid_o & ~rsp_ready_i;
        lock_mul_q <= grant_mul;
    end

endmodule

`default_nettype wire

/* design/fp_status_reg.sv */
// sticky exception flags and enables, updated by control ops and returned flags, drives exception_o
`default_nettype none
`timescale 1ns/100ps

module fp_status_reg import fp_pkg::*; (
    input  wire logic    clk,
    input  wire logic    rst,
    input  wire logic    ctl_valid_i,
    input  fp_req_t      ctl_req_i,
    input  wire logic    rsp_fire_i,
    input  fp_flags_t    rsp_flags_i,
    output fp_status_t   status_o,
    output logic         exception_o
);

    fp_flags_t mask;                                     // low bits of operand a
    fp_flags_t flags_d, en_d;

    assign mask = fp_flags_t'(ctl_req_i.a[FLAG_W-1:0]);

    always_comb begin
        flags_d = status_o.flags;
        en_d    = status_o.enables;
        if (rsp_fire_i)
            flags_d = flags_d | rsp_flags_i;             // accumulate
        if (ctl_valid_i) begin
            case (ctl_req_i.op)
                FTX: flags_d = flags_d | mask;
                FCX: flags_d = flags_d & ~mask;          // wins over a same-cycle response
                FEX: en_d    = en_d | mask;
                FDX: en_d    = en_d & ~mask;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            status_o    <= '0;
            exception_o <= 1'b0;
        end else begin
            status_o    <= '{enables: en_d, flags: flags_d};
            exception_o <= |(flags_d & en_d);            // any enabled flag raised
        end
    end

endmodule

`default_nettype wire

/* design/fp_unit.sv */
// FPU top level, wires dispatch, both execution units, the result arbiter and the status register
`default_nettype none
`timescale 1ns/100ps

module fp_unit import fp_pkg::*; (
    input  wire logic    clk,
    input  wire logic    rst,
    input  wire logic    req_valid_i,
    output logic         req_ready_o,
    input  fp_req_t      req_i,
    output logic         rsp_valid_o,
    input  wire logic    rsp_ready_i,
    output fp_rsp_t      rsp_o,
    output fp_status_t   status_o,
    output logic         exception_o
);

    // dispatch to units
    logic    misc_valid, misc_ready, mul_valid, mul_ready, ctl_valid;
    fp_req_t misc_req, mul_req, ctl_req;
    // units to arbiter
    logic    misc_out_valid, misc_out_ready, mul_out_valid, mul_out_ready, rsp_fire;
    fp_rsp_t misc_rsp, mul_rsp;

    fp_dispatch u_dispatch (
        .req_valid_i (req_valid_i), .req_i (req_i), .req_ready_o (req_ready_o),
        .misc_valid_o (misc_valid), .misc_req_o (misc_req), .misc_ready_i (misc_ready),
        .mul_valid_o (mul_valid), .mul_req_o (mul_req), .mul_ready_i (mul_ready),
        .ctl_valid_o (ctl_valid), .ctl_req_o (ctl_req)
    );

    fp_misc_unit u_misc (
        .clk (clk), .rst (rst),
        .in_valid_i (misc_valid), .in_req_i (misc_req), .in_ready_o (misc_ready),
        .status_i (status_o),
        .out_valid_o (misc_out_valid), .out_rsp_o (misc_rsp), .out_ready_i (misc_out_ready)
    );

    fp_mul_pipe u_mul (
        .clk (clk), .rst (rst),
        .in_valid_i (mul_valid), .in_req_i (mul_req), .in_ready_o (mul_ready),
        .out_valid_o (mul_out_valid), .out_rsp_o (mul_rsp), .out_ready_i (mul_out_ready)
    );

    fp_result_arbiter u_arb (
        .clk (clk), .rst (rst),
        .mul_valid_i (mul_out_valid), .mul_rsp_i (mul_rsp), .mul_ready_o (mul_out_ready),
        .misc_valid_i (misc_out_valid), .misc_rsp_i (misc_rsp), .misc_ready_o (misc_out_ready),
        .rsp_valid_o (rsp_valid_o), .rsp_o (rsp_o), .rsp_ready_i (rsp_ready_i),
        .rsp_fire_o (rsp_fire)
    );

    // returned flags fold into the sticky bits on the handshake
    fp_status_reg u_status (
        .clk (clk), .rst (rst),
        .ctl_valid_i (ctl_valid), .ctl_req_i (ctl_req),
        .rsp_fire_i (rsp_fire), .rsp_flags_i (rsp_o.flags),
        .status_o (status_o), .exception_o (exception_o)
    );

endmodule

`default_nettype wire

/* verif/fp_ref_model.svh */
// reference arithmetic for the FPU testbench that is included inside the testbench module body
`ifndef FP_REF_MODEL_SVH
`define FP_REF_MODEL_SVH

function automatic logic is_nan(input logic [31:0] x);
    return (x[30:23] == 8'hFF) && (x[22:0] != 23'd0);
endfunction

function automatic logic is_inf(input logic [31:0] x);
    return x[30:0] == 31'h7F80_0000;
endfunction

// ====================
// multiply with nearest even rounding and flush to zero
// ====================
function automatic fp_rsp_t mul_expected(input logic [31:0] a, input logic [31:0] b);
    fp_rsp_t     r;
    logic        s, a_z, b_z, g, st;
    logic [47:0] p;
    logic [24:0] m;                                      // 24 bit significand plus carry
    int          e;
    r   = '0;
    s   = a[31] ^ b[31];
    a_z = (a[30:23] == 8'd0);                            // subnormal counts as zero
    b_z = (b[30:23] == 8'd0);
    if (is_nan(a) || is_nan(b)) begin
        r.result     = is_nan(a) ? a : b;
        r.result[22] = 1'b1;                             // quiet bit
        r.flags.nv   = (is_nan(a) && !a[22]) || (is_nan(b) && !b[22]);
        return r;
    end
    if ((is_inf(a) && b_z) || (a_z && is_inf(b))) begin
        r.result   = QNAN_INF_ZERO;
        r.flags.nv = 1'b1;
        return r;
    end
    if (is_inf(a) || is_inf(b)) begin
        r.result = {s, 31'h7F80_0000};
        return r;
    end
    if (a_z || b_z) begin
        r.result = {s, 31'd0};
        return r;
    end
    p = {1'b1, a[22:0]} * {1'b1, b[22:0]};
    e = int'(a[30:23]) + int'(b[30:23]) - 127;
    if (p[47])
        e = e + 1;
    else
        p = p << 1;                                      // leading one now at bit 47
    g  = p[23];
    st = |p[22:0];
    m  = {1'b0, p[47:24]} + 25'(g && (st || p[24]));
    if (m[24]) begin
        e = e + 1;
        m = m >> 1;
    end
    r.flags.nx = g | st;
    if (e >= 255) begin
        r.result   = {s, 31'h7F80_0000};
        r.flags.of = 1'b1;
        r.flags.nx = 1'b1;
    end else if (e <= 0) begin
        r.result   = {s, 31'd0};
        r.flags.uf = 1'b1;
        r.flags.nx = 1'b1;
    end else begin
        r.result = {s, 8'(e), m[22:0]};
    end
    return r;
endfunction

// compare on an ordered key where both zeros fold to +0
function automatic fp_rsp_t cmp_expected(input logic [31:0] a, input logic [31:0] b);
    fp_rsp_t     r;
    logic [31:0] ka, kb;
    r = '0;
    if (is_nan(a) || is_nan(b)) begin
        r.result[CMP_UN] = 1'b1;
        r.flags.nv       = 1'b1;
        return r;
    end
    ka = (a[30:0] == 31'd0) ? 32'd0 : a;
    kb = (b[30:0] == 31'd0) ? 32'd0 : b;
    ka = ka[31] ? ~ka : (ka | 32'h8000_0000);
    kb = kb[31] ? ~kb : (kb | 32'h8000_0000);
    r.result[CMP_EQ] = (ka == kb);
    r.result[CMP_LT] = (ka < kb);
    r.result[CMP_LE] = (ka <= kb);
    return r;
endfunction

function automatic fp_rsp_t sign_expected(input fp_op_e op, input logic [31:0] a);
    fp_rsp_t r;
    r = '0;
    case (op)
        FMOV:    r.result = a;
        FNEG:    r.result = a ^ 32'h8000_0000;
        FABS:    r.result = a & 32'h7FFF_FFFF;
        FNABS:   r.result = a | 32'h8000_0000;
        FSIGN:   r.result = (a[30:0] == 31'd0) ? (a & 32'h8000_0000)
                                               : ((a & 32'h8000_0000) | 32'h3F80_0000);
        default: r.result = '0;
    endcase
    return r;
endfunction

`endif

/* verif/fp_unit_tb.sv */
// simulation top that drives the FPU with random and directed ops and scores each response by tag
`default_nettype none
`timescale 1ns/100ps

module fp_unit_tb import fp_pkg::*; ();

    localparam int          CLK_PERIOD = 8;
    localparam int          RST_CYCLES = 3;
    localparam int          TIMEOUT    = 2000;           // cycles allowed per wait
    localparam logic [31:0] SEED       = 32'd76;
    localparam int          N_SPECIAL  = 12;
    localparam int          N_MUL_RAND = 200;

    logic       clk;
    logic       rst;
    logic       req_valid_i, req_ready_o, rsp_valid_o, rsp_ready_i, exception_o;
    fp_req_t    req_i;
    fp_rsp_t    rsp_o;
    fp_status_t status_o;

    // ====================
    // scoreboard and status model
    // ====================
    fp_rsp_t             expected [2**TAG_W];
    logic [2**TAG_W-1:0] pending;                        // one bit per tag in flight
    logic [TAG_W-1:0]    next_tag;
    fp_flags_t           model_flags, model_en;
    logic [31:0]         rnd_state, bp_state;
    logic                bp_mode;                        // random response back-pressure
    logic                prev_stall;
    fp_rsp_t             prev_rsp;
    int                  errors, n_rsp;

    `include "fp_ref_model.svh"

    fp_unit DUT (
        .clk (clk), .rst (rst),
        .req_valid_i (req_valid_i), .req_ready_o (req_ready_o), .req_i (req_i),
        .rsp_valid_o (rsp_valid_o), .rsp_ready_i (rsp_ready_i), .rsp_o (rsp_o),
        .status_o (status_o), .exception_o (exception_o)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD/2) clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] rand32();
        rnd_state = lcg_next(rnd_state);
        return rnd_state;
    endfunction

    // mostly moderate exponents with raw bits now and then for nan, inf and subnormals
    function automatic logic [31:0] rand_operand();
        logic [31:0] r, f;
        r = rand32();
        f = rand32();
        if (r[31:29] == 3'b000)
            return f;
        return {r[28], 8'd96 + {2'b00, r[27:22]}, f[31:9]};
    endfunction

    function automatic logic [31:0] special(input int i);
        case (i)
            0:       return 32'h0000_0000;               // +0
            1:       return 32'h8000_0000;               // -0
            2:       return 32'h7F80_0000;               // +inf
            3:       return 32'hFF80_0000;               // -inf
            4:       return 32'h7FC0_0001;               // quiet nan
            5:       return 32'h7F80_0001;               // signaling nan
            6:       return 32'h3F80_0000;               // 1.0
            7:       return 32'hC000_0000;               // -2.0
            8:       return 32'h7F7F_FFFF;               // largest finite so the square overflows
            9:       return 32'h0080_0000;               // smallest normal so the square underflows
            10:      return 32'h0000_0001;               // subnormal
            default: return 32'h3FC0_0000;               // 1.5
        endcase
    endfunction

    function automatic fp_rsp_t expect_rsp(input fp_op_e op, input logic [31:0] a,
                                           input logic [31:0] b, input logic [TAG_W-1:0] tag);
        fp_rsp_t r;
        case (op)
            FMUL:               r = mul_expected(a, b);
            FCMP:               r = cmp_expected(a, b);
            FSTAT: begin
                r        = '0;
                r.result = {22'd0, model_en, model_flags};
            end
            FTX, FCX, FEX, FDX: r = '0;                  // plain ack
            default:            r = sign_expected(op, a);
        endcase
        r.tag = tag;
        return r;
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] want);
        assert (got === want)
        else begin
            errors++;
            $display("Error at %0t ns: %s got %h expected %h", $time, name, got, want);
        end
    endtask

    task automatic finish_run(input logic timed_out);
        $display("responses checked: %0d, errors: %0d", n_rsp, errors);
        if (errors == 0 && !timed_out)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    endtask

    // ====================
    // stimulus tasks
    // ====================
    task automatic issue(input fp_op_e op, input logic [31:0] a, input logic [31:0] b);
        int        n;
        fp_flags_t mask;
        mask = fp_flags_t'(a[FLAG_W-1:0]);
        n    = 0;
        while (pending[next_tag]) begin                  // tag still out
            @(posedge clk);
            #1;
            n++;
            if (n > TIMEOUT) begin
                $display("Timeout: tag %0d was never returned", next_tag);
                finish_run(1'b1);
            end
        end
        expected[next_tag] = expect_rsp(op, a, b, next_tag);
        pending[next_tag]  = 1'b1;
        req_i       = '{op: op, a: a, b: b, tag: next_tag};
        req_valid_i = 1'b1;
        n = 0;
        do begin
            @(posedge clk);
            n++;
            if (n > TIMEOUT) begin
                $display("Timeout: request with tag %0d was never accepted", next_tag);
                finish_run(1'b1);
            end
        end while (!req_ready_o);
        #1;
        req_valid_i = 1'b0;
        next_tag++;
        case (op)                                        // control ops act once accepted
            FTX: model_flags = model_flags | mask;
            FCX: model_flags = model_flags & ~mask;
            FEX: model_en    = model_en | mask;
            FDX: model_en    = model_en & ~mask;
            default: ;
        endcase
    endtask

    task automatic drain();
        int n;
        n = 0;
        while (pending != '0) begin
            @(posedge clk);
            #1;
            n++;
            if (n > TIMEOUT) begin
                $display("Timeout: responses still outstanding, mask %h", pending);
                finish_run(1'b1);
            end
        end
    endtask

    // response back-pressure from its own LCG stream
    always @(posedge clk) begin
        #1;
        bp_state    = lcg_next(bp_state);
        rsp_ready_i = bp_mode ? bp_state[31] : 1'b1;
    end

    // ====================
    // monitor
    // ====================
    always @(posedge clk) begin
        if (rst) begin
            prev_stall = 1'b0;
        end else begin
            check_value("status_o", 64'(status_o), 64'({model_en, model_flags}));
            check_value("exception_o", 64'(exception_o), 64'(|(model_flags & model_en)));
            if (prev_stall) begin                        // held response must not move
                check_value("rsp_valid_o", 64'(rsp_valid_o), 64'd1);
                check_value("rsp_o", 64'(rsp_o), 64'(prev_rsp));
            end
            if (rsp_valid_o && rsp_ready_i) begin
                n_rsp++;
                assert (pending[rsp_o.tag])
                else begin
                    errors++;
                    $display("Response with tag %0d arrived with no request outstanding",
                             rsp_o.tag);
                end
                if (pending[rsp_o.tag]) begin
                    check_value("rsp_o.result", 64'(rsp_o.result),
                                64'(expected[rsp_o.tag].result));
                    check_value("rsp_o.flags", 64'(rsp_o.flags),
                                64'(expected[rsp_o.tag].flags));
                    model_flags        = model_flags | expected[rsp_o.tag].flags;
                    pending[rsp_o.tag] = 1'b0;
                end
            end
            prev_stall = rsp_valid_o & ~rsp_ready_i;
            prev_rsp   = rsp_o;
        end
    end

    initial begin
        int          i, j;
        logic [31:0] r, x, y;
        rst         = 1'b1;
        req_valid_i = 1'b0;
        req_i       = '0;
        rsp_ready_i = 1'b1;
        bp_mode     = 1'b0;
        pending     = '0;
        next_tag    = '0;
        model_flags = '0;
        model_en    = '0;
        rnd_state   = SEED;
        bp_state    = ~SEED;
        errors      = 0;
        n_rsp       = 0;
        prev_stall  = 1'b0;
        prev_rsp    = '0;
        repeat (RST_CYCLES) @(posedge clk);
        #1;
        check_value("req_ready_o", 64'(req_ready_o), 64'd0);   // no request taken in reset
        rst = 1'b0;
        check_value("rsp_valid_o", 64'(rsp_valid_o), 64'd0);
        check_value("exception_o", 64'(exception_o), 64'd0);
        check_value("status_o", 64'(status_o), 64'd0);

        // multiply each pair of special values and then random operands
        for (i = 0; i < N_SPECIAL; i++)
            for (j = 0; j < N_SPECIAL; j++)
                issue(FMUL, special(i), special(j));
        for (i = 0; i < N_MUL_RAND; i++) begin
            x = rand_operand();
            y = rand_operand();
            issue(FMUL, x, y);
        end
        drain();

        // sign ops and compare with b sometimes equal to a
        for (i = 0; i < 120; i++) begin
            r = rand32();
            x = rand_operand();
            y = r[7] ? x : rand_operand();
            issue(fp_op_e'(4'(r[31:16] % 6)), x, y);
        end
        issue(FCMP, 32'h0000_0000, 32'h8000_0000);       // +0 vs -0
        issue(FCMP, 32'h7FC0_0000, 32'h3F80_0000);
        issue(FCMP, 32'h3F80_0000, 32'h7F80_0001);
        issue(FCMP, 32'hBF80_0000, 32'hC000_0000);
        issue(FSIGN, 32'h8000_0000, 32'd0);
        issue(FSIGN, 32'hC120_0000, 32'd0);
        drain();

        // back-pressure with units interleaved
        bp_mode = 1'b1;
        for (i = 0; i < 150; i++) begin
            r = rand32();
            x = rand_operand();
            y = rand_operand();
            if (r[31])
                issue(FMUL, x, y);
            else
                issue(fp_op_e'(4'(r[30:16] % 6)), x, y);
        end
        drain();
        bp_mode = 1'b0;

        // sticky flags read back and then cleared
        issue(FSTAT, 32'd0, 32'd0);
        drain();
        issue(FCX, 32'h1F, 32'd0);
        drain();
        check_value("status_o.flags", 64'(status_o.flags), 64'd0);
        issue(FSTAT, 32'd0, 32'd0);
        drain();

        // exception enables
        issue(FEX, 32'h01, 32'd0);
        issue(FMUL, 32'h7F80_0000, 32'h0000_0000);       // inf * 0 is invalid
        drain();
        check_value("exception_o", 64'(exception_o), 64'd1);
        issue(FDX, 32'h01, 32'd0);
        drain();
        check_value("exception_o", 64'(exception_o), 64'd0);
        issue(FCX, 32'h1F, 32'd0);
        issue(FEX, 32'h10, 32'd0);
        issue(FTX, 32'h10, 32'd0);                        // inexact with no arithmetic
        drain();
        check_value("exception_o", 64'(exception_o), 64'd1);
        issue(FSTAT, 32'd0, 32'd0);
        drain();
        finish_run(1'b0);
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+verif
design/fp_pkg.sv
design/fp_dispatch.sv
design/fp_misc_unit.sv
design/fp_mul_pipe.sv
design/fp_result_arbiter.sv
design/fp_status_reg.sv
design/fp_unit.sv
verif/fp_unit_tb.sv

/* Bender.yml */
package:
  name: fp_unit

sources:
  - files:
      - design/fp_pkg.sv
      - design/fp_dispatch.sv
      - design/fp_misc_unit.sv
      - design/fp_mul_pipe.sv
      - design/fp_result_arbiter.sv
      - design/fp_status_reg.sv
      - design/fp_unit.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/fp_unit_tb.sv
